//--- design/bankReadMux.sv
/* Bank read mux
   Sends the word address to every bank and registers the addressed bank's line */
`timescale 1ns/10ps

module bankReadMux (
    input  logic                  clk,
    input  logic                  rst,
    input  loaderPkg::lineIndex_t readAddr,
    output loaderPkg::wordAddr_t  wordAddr,
    input  loaderPkg::line_t      bankData [loaderPkg::NumBanks],
    output loaderPkg::line_t      readValue
);

    loaderPkg::bankSel_t bankSel;
    loaderPkg::bankSel_t bankSelQ;

    // Same split as on the write side
    assign bankSel  = loaderPkg::bankSel_t'(readAddr);
    assign wordAddr = loaderPkg::wordAddr_t'(readAddr >> $bits(loaderPkg::bankSel_t));

    // Select follows the bank's registered read by one cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            bankSelQ <= '0;
        end else begin
            bankSelQ <= bankSel;
        end
    end

    // Second pipeline stage
    always_ff @(posedge clk) begin
        if (rst) begin
            readValue <= '0;
        end else begin
            readValue <= bankData[bankSelQ];
        end
    end

endmodule

//--- design/lineBank.sv
/* Line bank
   Stores the lines whose index maps to this bank and reads one line per cycle */
`timescale 1ns/10ps

module lineBank #(
    parameter int BankIndex = 0
) (
    input  logic                 clk,
    input  logic                 rst,
    lineWriteIf.bank             writePort,
    input  loaderPkg::wordAddr_t wordAddr,
    output loaderPkg::line_t     readData
);

    loaderPkg::line_t mem [loaderPkg::LinesPerBank];

    logic                 selected;
    logic                 doWrite;
    logic                 doneReg;
    loaderPkg::wordAddr_t writeAddr;

    // Low index bits pick the bank, high bits the line inside it
    assign selected = writePort.writeEnable &&
                      (loaderPkg::bankSel_t'(writePort.lineIndex) ==
                       loaderPkg::bankSel_t'(BankIndex));
    assign writeAddr = loaderPkg::wordAddr_t'(writePort.lineIndex >>
                                              $bits(loaderPkg::bankSel_t));

    // The request is still held in the cycle after done, so skip that one
    assign doWrite = selected && !doneReg;

    always_ff @(posedge clk) begin
        if (rst) begin
            doneReg <= 1'b0;
        end else begin
            doneReg <= doWrite;
        end
    end

    always_ff @(posedge clk) begin
        if (doWrite) begin
            mem[writeAddr] <= writePort.writeValue;
        end
        readData <= mem[wordAddr];
    end

    assign writePort.writeDone[BankIndex] = doneReg;

endmodule

//--- design/lineWriteIf.sv
/* Line write bus
   Carries assembled lines from the UART receiver to the interleaved banks */
`timescale 1ns/10ps

interface lineWriteIf;

    // Held high by the receiver until a done bit comes back
    logic                  writeEnable;
    loaderPkg::lineIndex_t lineIndex;
    loaderPkg::line_t      writeValue;

    // One bit per bank, each driven by its own bank
    wire [loaderPkg::NumBanks-1:0] writeDone;

    modport receiver (
        output writeEnable,
        output lineIndex,
        output writeValue,
        input  writeDone
    );

    modport bank (
        input  writeEnable,
        input  lineIndex,
        input  writeValue,
        output writeDone
    );

endinterface

//--- design/loaderPkg.sv
/* Loader package
   UART timing, line and bank geometry, and the vector types shared by the loader */
package loaderPkg;

    // UART framing and timing
    localparam int ByteWidth       = 8;
    localparam int UartCycleLength = 8;
    localparam int HoldLength      = 4;

    // Line and bank geometry
    localparam int LineSize     = 4;
    localparam int LineWidth    = LineSize * ByteWidth;
    localparam int NumBanks     = 4;
    localparam int LinesPerBank = 8;
    localparam int TotalLines   = NumBanks * LinesPerBank;

    typedef logic [LineWidth-1:0] line_t;

    // Global line index with the bank number in its low bits
    typedef logic [$clog2(TotalLines)-1:0]   lineIndex_t;
    typedef logic [$clog2(NumBanks)-1:0]     bankSel_t;
    typedef logic [$clog2(LinesPerBank)-1:0] wordAddr_t;

    typedef logic [31:0] byteCount_t;

endpackage

//--- design/uartLineReceiver.sv
/* UART line receiver
   Samples an 8N1 line, packs bytes into lines and requests a bank write per line */
`timescale 1ns/10ps

module uartLineReceiver (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  uartRx,
    lineWriteIf.receiver          writePort,
    output loaderPkg::byteCount_t totalWriteSize
);

    typedef enum logic [2:0] {
        Idle        = 3'h0,
        StartBit    = 3'h1,
        Data        = 3'h2,
        StopBit     = 3'h3,
        WriteMemory = 3'h4,
        ClearBuffer = 3'h5
    } rxState_t;

    rxState_t state;
    rxState_t nextState;

    // Cycles within a bit, bits within a byte, bytes within a line
    logic [$clog2(loaderPkg::UartCycleLength+1)-1:0] cycleCount;
    logic [$clog2(loaderPkg::ByteWidth)-1:0]         bitCount;
    logic [$clog2(loaderPkg::LineSize)-1:0]          byteCount;

    loaderPkg::line_t      lineBuffer;
    loaderPkg::lineIndex_t lineIndex;
    loaderPkg::byteCount_t byteTotal;

    logic holdDone;
    logic bitDone;
    logic sampleData;
    logic sampleStop;
    logic anyDone;

    // Terminal counts for the start bit check and for one full bit time
    assign holdDone = (cycleCount == loaderPkg::HoldLength);
    assign bitDone  = (cycleCount == loaderPkg::UartCycleLength);

    assign sampleData = (state == Data) && bitDone;
    assign sampleStop = (state == StopBit) && bitDone;

    // Only the selected bank ever acknowledges
    assign anyDone = |writePort.writeDone;

    assign writePort.writeEnable = (state == WriteMemory);
    assign writePort.lineIndex   = lineIndex;
    assign writePort.writeValue  = lineBuffer;
    assign totalWriteSize        = byteTotal;

    always_comb begin
        nextState = state;
        unique case (state)
            Idle: begin
                if (!uartRx) begin
                    nextState = StartBit;
                end
            end
            StartBit: begin
                // A glitch shorter than the hold time drops the frame
                if (uartRx) begin
                    nextState = Idle;
                end else if (holdDone) begin
                    nextState = Data;
                end
            end
            Data: begin
                if (bitDone && bitCount == loaderPkg::ByteWidth - 1) begin
                    nextState = StopBit;
                end
            end
            StopBit: begin
                if (bitDone) begin
                    nextState = (byteCount == loaderPkg::LineSize - 1) ? WriteMemory : Idle;
                end
            end
            WriteMemory: begin
                if (anyDone) begin
                    nextState = ClearBuffer;
                end
            end
            ClearBuffer: begin
                nextState = Idle;
            end
            default: begin
                nextState = Idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= Idle;
        end else begin
            state <= nextState;
        end
    end

    // Bit timing counter that runs only while a frame is being received
    always_ff @(posedge clk) begin
        if (rst) begin
            cycleCount <= '0;
        end else if ((state == StartBit && !holdDone) ||
                     (state == Data && !bitDone) ||
                     (state == StopBit && !bitDone)) begin
            cycleCount <= cycleCount + 1'b1;
        end else begin
            cycleCount <= '0;
        end
    end

    // Bit and byte position inside the current line
    always_ff @(posedge clk) begin
        if (rst) begin
            bitCount  <= '0;
            byteCount <= '0;
        end else if (state == ClearBuffer) begin
            bitCount  <= '0;
            byteCount <= '0;
        end else begin
            if (sampleData) begin
                bitCount <= bitCount + 1'b1;
            end
            if (sampleStop) begin
                byteCount <= byteCount + 1'b1;
            end
        end
    end

    // Byte 0 lands in the low bits and each byte arrives LSB first
    always_ff @(posedge clk) begin
        if (state == ClearBuffer) begin
            lineBuffer <= '0;
        end else if (sampleData) begin
            lineBuffer[{byteCount, bitCount}] <= uartRx;
        end
    end

    // Line index wraps at the total line count
    always_ff @(posedge clk) begin
        if (rst) begin
            lineIndex <= '0;
            byteTotal <= '0;
        end else if (state == ClearBuffer) begin
            lineIndex <= lineIndex + 1'b1;
            byteTotal <= byteTotal + loaderPkg::byteCount_t'(loaderPkg::LineSize);
        end
    end

endmodule

//--- design/uartMemoryLoader.sv
/* UART memory loader
   Serial receiver feeding interleaved line banks, read back through one port */
`timescale 1ns/10ps

module uartMemoryLoader (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  uartRx,
    input  loaderPkg::lineIndex_t readAddr,
    output loaderPkg::line_t      readValue,
    output loaderPkg::byteCount_t totalWriteSize
);

    // Write path from receiver to banks
    lineWriteIf writeBus ();

    // Read path between banks and mux
    loaderPkg::wordAddr_t wordAddr;
    loaderPkg::line_t     bankData [loaderPkg::NumBanks];

    uartLineReceiver receiver_i (
        .clk            (clk),
        .rst            (rst),
        .uartRx         (uartRx),
        .writePort      (writeBus.receiver),
        .totalWriteSize (totalWriteSize)
    );

    // Line i lives in bank i mod NumBanks
    for (genvar i = 0; i < loaderPkg::NumBanks; i++) begin : gBank
        lineBank #(
            .BankIndex (i)
        ) bank_i (
            .clk       (clk),
            .rst       (rst),
            .writePort (writeBus.bank),
            .wordAddr  (wordAddr),
            .readData  (bankData[i])
        );
    end

    bankReadMux readMux_i (
        .clk       (clk),
        .rst       (rst),
        .readAddr  (readAddr),
        .wordAddr  (wordAddr),
        .bankData  (bankData),
        .readValue (readValue)
    );

endmodule

//--- list.f
+incdir+test
design/loaderPkg.sv
design/lineWriteIf.sv
design/uartLineReceiver.sv
design/lineBank.sv
design/bankReadMux.sv
design/uartMemoryLoader.sv
test/uartMemoryLoaderTb.sv

//--- test/loaderTbUtil.svh
/* Loader testbench helpers
   Random byte source, UART frame driver, typed compare tasks and error counters */
`ifndef LOADER_TB_UTIL_SVH
`define LOADER_TB_UTIL_SVH

// One UART bit lasts this many clock cycles on the receiver side
localparam int BitCycles  = loaderPkg::UartCycleLength + 1;
localparam int IdleCycles = 4;
localparam int LcgSeed    = 57;

int lineErrors  = 0;
int countErrors = 0;
int waitErrors  = 0;

logic [31:0] lcgState = LcgSeed;

// Linear congruential step whose upper middle bits give the byte
function automatic logic [7:0] lcgByte();
    lcgState = lcgState * 32'd1103515245 + 32'd12345;
    return lcgState[23:16];
endfunction

// Start bit, eight data bits LSB first, stop bit, then idle line
task automatic sendByte(input logic [loaderPkg::ByteWidth-1:0] value);
    @(negedge clk);
    uartRx = 1'b0;
    repeat (BitCycles) @(negedge clk);
    for (int i = 0; i < loaderPkg::ByteWidth; i++) begin
        uartRx = value[i];
        repeat (BitCycles) @(negedge clk);
    end
    uartRx = 1'b1;
    repeat (BitCycles) @(negedge clk);
    repeat (IdleCycles) @(negedge clk);
endtask

// Byte 0 of the line goes out first
task automatic sendLine(input loaderPkg::line_t value);
    for (int k = 0; k < loaderPkg::LineSize; k++) begin
        sendByte(value[k*loaderPkg::ByteWidth +: loaderPkg::ByteWidth]);
    end
endtask

task automatic checkLine(
    input string            testName,
    input loaderPkg::line_t expected,
    input loaderPkg::line_t actual
);
    if (actual !== expected) begin
        $display("ERROR %s: line expected %h, actual %h", testName, expected, actual);
        lineErrors++;
    end
endtask

task automatic checkCount(
    input string                 testName,
    input loaderPkg::byteCount_t expected,
    input loaderPkg::byteCount_t actual
);
    if (actual !== expected) begin
        $display("ERROR %s: byte count expected %0d, actual %0d",
                 testName, expected, actual);
        countErrors++;
    end
endtask

`endif

//--- test/uartMemoryLoaderTb.sv
/* UART memory loader testbench
   Directed tests for line assembly, bank interleaving, false starts and index wrap */
`timescale 1ns/10ps

module uartMemoryLoaderTb;

    // Frames sent by all tests together set the run limit
    localparam int FramesSent     = 176;
    localparam int CycleLimit     = FramesSent * 100 + 2000;
    localparam int CountWaitLimit = 10;
    localparam int WrapLines      = loaderPkg::TotalLines + 1;

    logic                  clk;
    logic                  rst;
    logic                  uartRx;
    loaderPkg::lineIndex_t readAddr;
    loaderPkg::line_t      readValue;
    loaderPkg::byteCount_t totalWriteSize;

    int cycleCount = 0;

    `include "loaderTbUtil.svh"

    uartMemoryLoader uartMemoryLoader_i (
        .clk            (clk),
        .rst            (rst),
        .uartRx         (uartRx),
        .readAddr       (readAddr),
        .readValue      (readValue),
        .totalWriteSize (totalWriteSize)
    );

    initial begin
        clk = 1'b0;
    end

    always #5 clk = ~clk;

    // Run limit
    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= CycleLimit) begin
            $display("Run stopped: no finish after %0d clock cycles", CycleLimit);
            $display("Something failed");
            $finish;
        end
    end

    task automatic applyReset();
        @(negedge clk);
        rst    = 1'b1;
        uartRx = 1'b1;
        repeat (2) @(negedge clk);
        rst = 1'b0;
    endtask

    // Line data shows up two rising edges after the address
    task automatic readLine(
        input string                 testName,
        input loaderPkg::lineIndex_t addr,
        input loaderPkg::line_t      expected
    );
        @(negedge clk);
        readAddr = addr;
        repeat (2) @(negedge clk);
        checkLine(testName, expected, readValue);
    endtask

    // The count follows the last stop bit within a few cycles
    task automatic awaitCount(input string testName, input loaderPkg::byteCount_t expected);
        int waited;
        waited = 0;
        while (totalWriteSize < expected && waited < CountWaitLimit) begin
            @(negedge clk);
            waited++;
        end
        if (totalWriteSize < expected) begin
            $display("%s: byte count did not reach %0d within %0d cycles",
                     testName, expected, CountWaitLimit);
            waitErrors++;
        end
    endtask

    // Bytes that differ per line and per position
    function automatic loaderPkg::line_t patternLine(input int idx);
        loaderPkg::line_t value;
        value = '0;
        for (int k = 0; k < loaderPkg::LineSize; k++) begin
            value[k*loaderPkg::ByteWidth +: loaderPkg::ByteWidth] = 8'((idx * 16 + k) ^ 8'h5A);
        end
        return value;
    endfunction

    task automatic testOneLine();
        applyReset();
        sendByte(8'h11);
        sendByte(8'h22);
        sendByte(8'h33);
        sendByte(8'h44);
        awaitCount("oneLine", 4);
        checkCount("oneLine", 4, totalWriteSize);
        readLine("oneLine", 0, 32'h4433_2211);
    endtask

    // Eight lines touch every bank at two word addresses
    task automatic testInterleave();
        applyReset();
        for (int i = 0; i < 8; i++) begin
            sendLine(patternLine(i));
            awaitCount("interleave", loaderPkg::byteCount_t'(4 * (i + 1)));
        end
        for (int i = 0; i < 8; i++) begin
            readLine("interleave", loaderPkg::lineIndex_t'(i), patternLine(i));
        end
    endtask

    task automatic testFalseStart();
        applyReset();
        @(negedge clk);
        uartRx = 1'b0;
        repeat (loaderPkg::HoldLength - 2) @(negedge clk);
        uartRx = 1'b1;
        repeat (2 * loaderPkg::HoldLength) @(negedge clk);
        sendLine(32'hC3A5_5A3C);
        awaitCount("falseStart", 4);
        checkCount("falseStart", 4, totalWriteSize);
        readLine("falseStart", 0, 32'hC3A5_5A3C);
    endtask

    task automatic testPartialLine();
        applyReset();
        sendByte(8'hDE);
        sendByte(8'hAD);
        sendByte(8'hBE);
        checkCount("partialLine", 0, totalWriteSize);
        sendByte(8'hEF);
        awaitCount("partialLine", 4);
        checkCount("partialLine", 4, totalWriteSize);
        readLine("partialLine", 0, 32'hEFBE_ADDE);
    endtask

    // One line more than the banks hold, so line 0 is overwritten
    task automatic testRandomWrap();
        loaderPkg::line_t expectedLines [WrapLines];
        loaderPkg::line_t value;
        applyReset();
        for (int i = 0; i < WrapLines; i++) begin
            value = '0;
            for (int k = 0; k < loaderPkg::LineSize; k++) begin
                value[k*loaderPkg::ByteWidth +: loaderPkg::ByteWidth] = lcgByte();
            end
            expectedLines[i] = value;
            sendLine(value);
            awaitCount("randomWrap", loaderPkg::byteCount_t'(4 * (i + 1)));
        end
        checkCount("randomWrap", loaderPkg::byteCount_t'(4 * WrapLines), totalWriteSize);
        readLine("randomWrap", 0, expectedLines[WrapLines-1]);
        for (int i = 1; i < loaderPkg::TotalLines; i++) begin
            readLine("randomWrap", loaderPkg::lineIndex_t'(i), expectedLines[i]);
        end
    endtask

    initial begin
        rst      = 1'b1;
        uartRx   = 1'b1;
        readAddr = '0;

        testOneLine();
        testInterleave();
        testFalseStart();
        testPartialLine();
        testRandomWrap();

        $display("Errors: %0d line, %0d count, %0d wait", lineErrors, countErrors, waitErrors);
        if (lineErrors + countErrors + waitErrors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule
